// File: build.f
rtl/cache_pkg.sv
rtl/icache.sv
rtl/dcache.sv
rtl/mem_arbiter.sv
rtl/block_memory.sv
rtl/cache_subsystem_top.sv
verification/cache_tb_assert.sv
verification/cache_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= cache_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := === PASS ===

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qF -- "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/cache_tb.sv
`timescale 1ns/1ps

module cache_tb;
    import cache_pkg::*;

    localparam int PORT_I     = 0;
    localparam int PORT_D     = 1;
    localparam int PORT_BOTH  = 2;
    localparam int MAX_WAIT   = 200;
    localparam int NUM_RANDOM = 32;

    typedef struct {
        string                name;
        int                   port;
        bit                   we;
        logic [WORD_SIZE-1:0] addr;
        logic [WORD_SIZE-1:0] wdata;
        logic [WORD_SIZE-1:0] exp_idata;
        logic [WORD_SIZE-1:0] exp_data;
        int                   inc_i;
        int                   inc_d;
    } row_t;

    logic                 Clk = 1'b0;
    logic                 i_reset;
    logic                 i_ireq;
    logic [WORD_SIZE-1:0] i_iaddr;
    logic                 i_dreq;
    logic                 i_dwe;
    logic [WORD_SIZE-1:0] i_daddr;
    logic [WORD_SIZE-1:0] i_dwdata;
    logic                 o_iack;
    logic [WORD_SIZE-1:0] o_irdata;
    logic                 o_dack;
    logic [WORD_SIZE-1:0] o_drdata;
    logic [15:0]          o_imiss_count;
    logic [15:0]          o_dmiss_count;

    row_t                 rows[$];
    logic [WORD_SIZE-1:0] shadow [logic [WORD_SIZE-1:0]];
    logic [TAG_SIZE-1:0]  tag_shadow [2][NUM_LINES];
    bit                   valid_shadow [2][NUM_LINES];
    logic [31:0]          lfsr_state = 32'hae27f2a0;
    int                   model_imiss = 0;
    int                   model_dmiss = 0;
    int                   errors = 0;
    int                   tests_run = 0;
    int                   tests_failed = 0;

    cache_subsystem_top #(
        .MEM_LATENCY(4)
    ) UUT (
        .Clk(Clk), .i_reset(i_reset),
        .i_ireq(i_ireq), .i_iaddr(i_iaddr),
        .i_dreq(i_dreq), .i_dwe(i_dwe), .i_daddr(i_daddr), .i_dwdata(i_dwdata),
        .o_iack(o_iack), .o_irdata(o_irdata), .o_dack(o_dack), .o_drdata(o_drdata),
        .o_imiss_count(o_imiss_count), .o_dmiss_count(o_dmiss_count)
    );

    always #4 Clk = ~Clk;

    // fibonacci lfsr with taps 32, 22, 2, 1, one step per bit taken
    function automatic logic [15:0] lfsr_take(input int nbits);
        logic [15:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < nbits; k++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[14:0], fb};
        end
        return v;
    endfunction

    // a combined row fetches from the data address with the top bit flipped
    function automatic logic [WORD_SIZE-1:0] fetch_addr(input int port,
                                                        input logic [WORD_SIZE-1:0] addr);
        return (port == PORT_BOTH) ? (addr ^ 16'h8000) : addr;
    endfunction

    // side 0 is the instruction cache, side 1 the data cache; returns 1 on a miss
    function automatic int model_access(input int side, input logic [WORD_SIZE-1:0] addr);
        logic [TAG_SIZE-1:0]   tag;
        logic [INDEX_SIZE-1:0] idx;
        tag = addr[WORD_SIZE-1 -: TAG_SIZE];
        idx = addr[OFFSET_SIZE +: INDEX_SIZE];
        if (valid_shadow[side][idx] && tag_shadow[side][idx] == tag) begin
            return 0;
        end
        valid_shadow[side][idx] = 1'b1;
        tag_shadow[side][idx] = tag;
        return 1;
    endfunction

    // a negative increment means the model supplies the expected miss count
    task automatic add_row(input string name, input int port, input bit we,
                           input logic [WORD_SIZE-1:0] addr, input logic [WORD_SIZE-1:0] wdata,
                           input int inc_i, input int inc_d);
        row_t row;
        int   miss;
        row = '{name, port, we, addr, wdata, 16'h0, 16'h0, inc_i, inc_d};
        if (port != PORT_D) begin
            miss = model_access(0, fetch_addr(port, addr));
            model_imiss += miss;
            row.exp_idata = fetch_addr(port, addr) ^ MEM_PATTERN;
            if (inc_i < 0) begin
                row.inc_i = miss;
            end
        end
        if (port != PORT_I) begin
            miss = model_access(1, addr);
            model_dmiss += miss;
            if (we) begin
                shadow[addr] = wdata;
            end
            row.exp_data = shadow.exists(addr) ? shadow[addr] : (addr ^ MEM_PATTERN);
            if (inc_d < 0) begin
                row.inc_d = miss;
            end
        end
        rows.push_back(row);
    endtask

    task automatic check(input string what, input logic [15:0] expected,
                         input logic [15:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", what, expected, actual);
        end
    endtask

    task automatic wait_acks(input bit use_i, input bit use_d, input bit level, output bit ok);
        int n;
        n = 0;
        ok = 1'b0;
        while (!ok && n < MAX_WAIT) begin
            @(negedge Clk);
            ok = (!use_i || o_iack == level) && (!use_d || o_dack == level);
            n++;
        end
    endtask

    initial begin
        row_t        row;
        bit          ok;
        bit          use_i;
        bit          use_d;
        bit          timed_out;
        logic [15:0] ibase;
        logic [15:0] dbase;
        logic [15:0] r_we;
        logic [15:0] r_addr;
        logic [15:0] r_data;
        int          errs_before;

        timed_out = 1'b0;
        i_reset  <= 1'b1;
        i_ireq   <= 1'b0;
        i_iaddr  <= '0;
        i_dreq   <= 1'b0;
        i_dwe    <= 1'b0;
        i_daddr  <= '0;
        i_dwdata <= '0;

        add_row("i_miss_fetch", PORT_I, 1'b0, 16'h0100, 16'h0000, 1, 0);
        add_row("i_hit_same_line", PORT_I, 1'b0, 16'h0103, 16'h0000, 0, 0);
        add_row("d_write_alloc", PORT_D, 1'b1, 16'h0200, 16'hbeef, 0, 1);
        add_row("d_read_back", PORT_D, 1'b0, 16'h0200, 16'h0000, 0, 0);
        add_row("d_write_word", PORT_D, 1'b1, 16'h0201, 16'h1234, 0, 0);
        add_row("d_read_word", PORT_D, 1'b0, 16'h0201, 16'h0000, 0, 0);
        add_row("d_read_neighbor", PORT_D, 1'b0, 16'h0202, 16'h0000, 0, 0);
        add_row("d_evict_dirty", PORT_D, 1'b0, 16'h0600, 16'h0000, 0, 1);
        add_row("d_reload_dirty", PORT_D, 1'b0, 16'h0200, 16'h0000, 0, 1);
        add_row("d_reload_word", PORT_D, 1'b0, 16'h0201, 16'h0000, 0, 0);
        add_row("both_read", PORT_BOTH, 1'b0, 16'h0a04, 16'h0000, 1, 1);
        add_row("both_write", PORT_BOTH, 1'b1, 16'h0c08, 16'hc0de, 1, 1);
        add_row("both_hit", PORT_BOTH, 1'b0, 16'h0c09, 16'h0000, 0, 0);
        add_row("d_read_merged", PORT_D, 1'b0, 16'h0c08, 16'h0000, 0, 0);
        // random rows stay in four tags so that hits, misses and evictions all occur
        for (int k = 0; k < NUM_RANDOM; k++) begin
            r_we = lfsr_take(1);
            r_addr = lfsr_take(7);
            r_data = lfsr_take(16);
            add_row($sformatf("rand_%0d", k), PORT_D, r_we[0], r_addr, r_data, 0, -1);
        end

        repeat (2) @(posedge Clk);
        i_reset <= 1'b0;
        @(negedge Clk);
        check("reset_state iack", 16'h0, 16'(o_iack));
        check("reset_state dack", 16'h0, 16'(o_dack));
        check("reset_state imiss", 16'h0, o_imiss_count);
        check("reset_state dmiss", 16'h0, o_dmiss_count);
        tests_run++;
        tests_failed += (errors != 0) ? 1 : 0;
        $display("test reset_state: %s", (errors == 0) ? "passed" : "failed");

        for (int r = 0; r < rows.size() && !timed_out; r++) begin
            row = rows[r];
            use_i = (row.port != PORT_D);
            use_d = (row.port != PORT_I);
            errs_before = errors;
            ibase = o_imiss_count;
            dbase = o_dmiss_count;
            @(posedge Clk);
            if (use_i) begin
                i_ireq  <= 1'b1;
                i_iaddr <= fetch_addr(row.port, row.addr);
            end
            if (use_d) begin
                i_dreq   <= 1'b1;
                i_dwe    <= row.we;
                i_daddr  <= row.addr;
                i_dwdata <= row.wdata;
            end
            wait_acks(use_i, use_d, 1'b1, ok);
            if (ok) begin
                if (use_i) begin
                    check({row.name, " irdata"}, row.exp_idata, o_irdata);
                end
                if (use_d && !row.we) begin
                    check({row.name, " drdata"}, row.exp_data, o_drdata);
                end
                check({row.name, " imiss"}, 16'(row.inc_i), o_imiss_count - ibase);
                check({row.name, " dmiss"}, 16'(row.inc_d), o_dmiss_count - dbase);
                @(posedge Clk);
                i_ireq <= 1'b0;
                i_dreq <= 1'b0;
                wait_acks(use_i, use_d, 1'b0, ok);
            end
            tests_run++;
            if (!ok) begin
                $display("test %s stopped: the cache handshake did not finish in time", row.name);
                errors++;
                tests_failed++;
                timed_out = 1'b1;
            end else begin
                tests_failed += (errors != errs_before) ? 1 : 0;
                $display("test %s: %s", row.name, (errors == errs_before) ? "passed" : "failed");
            end
        end

        if (!timed_out) begin
            errs_before = errors;
            check("final_counts imiss", 16'(model_imiss), o_imiss_count);
            check("final_counts dmiss", 16'(model_dmiss), o_dmiss_count);
            tests_run++;
            tests_failed += (errors != errs_before) ? 1 : 0;
            $display("test final_counts: %s", (errors == errs_before) ? "passed" : "failed");
        end

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: verification/cache_tb_assert.sv
`timescale 1ns/1ps

module cache_tb_assert (
    input logic                                  Clk,
    input logic                                  i_reset,
    input logic                                  i_ireq,
    input logic                                  i_iack,
    input logic                                  i_dreq,
    input logic                                  i_dack,
    input logic                                  i_mem_req,
    input logic                                  i_mem_we,
    input logic [cache_pkg::BLOCK_ADDR_SIZE-1:0] i_mem_addr,
    input logic [cache_pkg::BLOCK_SIZE-1:0]      i_mem_wdata,
    input logic                                  i_mem_ack
);
    // an ack may outlive its request only by the cycle the cache needs to see it fall
    a_iack_has_req: assert property (@(posedge Clk) disable iff (i_reset)
        i_iack |-> (i_ireq || $past(i_ireq)))
        else $error("instruction ack high without a request");

    a_dack_has_req: assert property (@(posedge Clk) disable iff (i_reset)
        i_dack |-> (i_dreq || $past(i_dreq)))
        else $error("data ack high without a request");

    // write data only matters while a write is in flight
    a_mem_hold: assert property (@(posedge Clk) disable iff (i_reset)
        (i_mem_req && !i_mem_ack) |=> (i_mem_req && $stable(i_mem_we) && $stable(i_mem_addr)
                                       && (!i_mem_we || $stable(i_mem_wdata))))
        else $error("memory request or payload changed before ack");

    a_mem_ack_drop: assert property (@(posedge Clk) disable iff (i_reset)
        (!i_mem_req && i_mem_ack) |=> !i_mem_ack)
        else $error("memory ack stayed high after the request fell");

endmodule

bind cache_subsystem_top cache_tb_assert u_handshake_assert (
    .Clk(Clk), .i_reset(i_reset),
    .i_ireq(i_ireq), .i_iack(o_iack), .i_dreq(i_dreq), .i_dack(o_dack),
    .i_mem_req(mem_req), .i_mem_we(mem_we), .i_mem_addr(mem_addr),
    .i_mem_wdata(mem_wdata), .i_mem_ack(mem_ack)
);

// File: rtl/cache_subsystem_top.sv
`timescale 1ns/1ps

module cache_subsystem_top #(
    parameter int MEM_LATENCY = 4
) (
    input  logic                            Clk,
    input  logic                            i_reset,
    input  logic                            i_ireq,
    input  logic [cache_pkg::WORD_SIZE-1:0] i_iaddr,
    input  logic                            i_dreq,
    input  logic                            i_dwe,
    input  logic [cache_pkg::WORD_SIZE-1:0] i_daddr,
    input  logic [cache_pkg::WORD_SIZE-1:0] i_dwdata,
    output logic                            o_iack,
    output logic [cache_pkg::WORD_SIZE-1:0] o_irdata,
    output logic                            o_dack,
    output logic [cache_pkg::WORD_SIZE-1:0] o_drdata,
    output logic [15:0]                     o_imiss_count,
    output logic [15:0]                     o_dmiss_count
);
    import cache_pkg::*;

    logic                       ic_mem_req;
    logic [BLOCK_ADDR_SIZE-1:0] ic_mem_addr;
    logic                       ic_mem_ack;
    logic                       dc_mem_req;
    logic                       dc_mem_we;
    logic [BLOCK_ADDR_SIZE-1:0] dc_mem_addr;
    logic [BLOCK_SIZE-1:0]      dc_mem_wdata;
    logic                       dc_mem_ack;
    logic [BLOCK_SIZE-1:0]      cache_rdata;

    logic                       mem_req;
    logic                       mem_we;
    logic [BLOCK_ADDR_SIZE-1:0] mem_addr;
    logic [BLOCK_SIZE-1:0]      mem_wdata;
    logic                       mem_ack;
    logic [BLOCK_SIZE-1:0]      mem_rdata;

    icache u_icache (
        .Clk(Clk), .i_reset(i_reset),
        .i_req(i_ireq), .i_addr(i_iaddr),
        .i_mem_ack(ic_mem_ack), .i_mem_rdata(cache_rdata),
        .o_ack(o_iack), .o_rdata(o_irdata),
        .o_mem_req(ic_mem_req), .o_mem_addr(ic_mem_addr),
        .o_miss_count(o_imiss_count)
    );

    dcache u_dcache (
        .Clk(Clk), .i_reset(i_reset),
        .i_req(i_dreq), .i_we(i_dwe), .i_addr(i_daddr), .i_wdata(i_dwdata),
        .i_mem_ack(dc_mem_ack), .i_mem_rdata(cache_rdata),
        .o_ack(o_dack), .o_rdata(o_drdata),
        .o_mem_req(dc_mem_req), .o_mem_we(dc_mem_we),
        .o_mem_addr(dc_mem_addr), .o_mem_wdata(dc_mem_wdata),
        .o_miss_count(o_dmiss_count)
    );

    mem_arbiter u_arbiter (
        .Clk(Clk), .i_reset(i_reset),
        .i_d_req(dc_mem_req), .i_d_we(dc_mem_we),
        .i_d_addr(dc_mem_addr), .i_d_wdata(dc_mem_wdata),
        .i_i_req(ic_mem_req), .i_i_addr(ic_mem_addr),
        .i_mem_ack(mem_ack), .i_mem_rdata(mem_rdata),
        .o_d_ack(dc_mem_ack), .o_i_ack(ic_mem_ack), .o_rdata(cache_rdata),
        .o_mem_req(mem_req), .o_mem_we(mem_we),
        .o_mem_addr(mem_addr), .o_mem_wdata(mem_wdata)
    );

    block_memory #(
        .MEM_LATENCY(MEM_LATENCY)
    ) u_memory (
        .Clk(Clk), .i_reset(i_reset),
        .i_req(mem_req), .i_we(mem_we), .i_addr(mem_addr), .i_wdata(mem_wdata),
        .o_ack(mem_ack), .o_rdata(mem_rdata)
    );

endmodule

// File: rtl/block_memory.sv
`timescale 1ns/1ps

module block_memory #(
    parameter int MEM_LATENCY = 4
) (
    input  logic                                  Clk,
    input  logic                                  i_reset,
    input  logic                                  i_req,
    input  logic                                  i_we,
    input  logic [cache_pkg::BLOCK_ADDR_SIZE-1:0] i_addr,
    input  logic [cache_pkg::BLOCK_SIZE-1:0]      i_wdata,
    output logic                                  o_ack,
    output logic [cache_pkg::BLOCK_SIZE-1:0]      o_rdata
);
    import cache_pkg::*;

    localparam int CNT_W = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(MEM_LATENCY - 1);

    logic [BLOCK_SIZE-1:0] mem [2**BLOCK_ADDR_SIZE];
    logic [CNT_W-1:0]      count;
    logic                  fire;

    // known start image so the testbench can predict every read
    initial begin
        logic [WORD_SIZE-1:0] word_addr;
        for (int b = 0; b < 2**BLOCK_ADDR_SIZE; b++) begin
            for (int w = 0; w < LINE_WORDS; w++) begin
                word_addr = WORD_SIZE'(b * LINE_WORDS + w);
                mem[b][(LINE_WORDS-1-w)*WORD_SIZE +: WORD_SIZE] = word_addr ^ MEM_PATTERN;
            end
        end
    end

    // the access completes on the MEM_LATENCY-th edge that sees req high
    assign fire = i_req && !o_ack && (count == LAST);

    always_ff @(posedge Clk) begin
        if (i_reset) begin
            o_ack <= 1'b0;
            count <= '0;
        end else if (fire) begin
            o_ack <= 1'b1;
            count <= '0;
        end else if (i_req && !o_ack) begin
            count <= count + CNT_W'(1);
        end else if (o_ack && !i_req) begin
            o_ack <= 1'b0;
        end
    end

    always_ff @(posedge Clk) begin
        if (fire) begin
            if (i_we) begin
                mem[i_addr] <= i_wdata;
            end
            o_rdata <= mem[i_addr];
        end
    end

endmodule

// File: rtl/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                                  Clk,
    input  logic                                  i_reset,
    input  logic                                  i_d_req,
    input  logic                                  i_d_we,
    input  logic [cache_pkg::BLOCK_ADDR_SIZE-1:0] i_d_addr,
    input  logic [cache_pkg::BLOCK_SIZE-1:0]      i_d_wdata,
    input  logic                                  i_i_req,
    input  logic [cache_pkg::BLOCK_ADDR_SIZE-1:0] i_i_addr,
    input  logic                                  i_mem_ack,
    input  logic [cache_pkg::BLOCK_SIZE-1:0]      i_mem_rdata,
    output logic                                  o_d_ack,
    output logic                                  o_i_ack,
    output logic [cache_pkg::BLOCK_SIZE-1:0]      o_rdata,
    output logic                                  o_mem_req,
    output logic                                  o_mem_we,
    output logic [cache_pkg::BLOCK_ADDR_SIZE-1:0] o_mem_addr,
    output logic [cache_pkg::BLOCK_SIZE-1:0]      o_mem_wdata
);
    typedef enum logic [1:0] {G_IDLE, G_DATA, G_INST} grant_t;

    grant_t grant;

    // data cache wins when both ask in the same cycle
    always_ff @(posedge Clk) begin
        if (i_reset) begin
            grant <= G_IDLE;
        end else begin
            unique case (grant)
                G_IDLE: begin
                    if (i_d_req) begin
                        grant <= G_DATA;
                    end else if (i_i_req) begin
                        grant <= G_INST;
                    end
                end
                G_DATA: begin
                    if (!i_d_req && !i_mem_ack) begin
                        grant <= G_IDLE;
                    end
                end
                G_INST: begin
                    if (!i_i_req && !i_mem_ack) begin
                        grant <= G_IDLE;
                    end
                end
                default: grant <= G_IDLE;
            endcase
        end
    end

    assign o_mem_req   = ((grant == G_DATA) && i_d_req) || ((grant == G_INST) && i_i_req);
    // instruction fetches only ever read
    assign o_mem_we    = (grant == G_DATA) && i_d_we;
    assign o_mem_addr  = (grant == G_INST) ? i_i_addr : i_d_addr;
    assign o_mem_wdata = i_d_wdata;

    assign o_d_ack = (grant == G_DATA) && i_mem_ack;
    assign o_i_ack = (grant == G_INST) && i_mem_ack;
    assign o_rdata = i_mem_rdata;

endmodule

// File: rtl/dcache.sv
`timescale 1ns/1ps

module dcache (
    input  logic                                  Clk,
    input  logic                                  i_reset,
    input  logic                                  i_req,
    input  logic                                  i_we,
    input  logic [cache_pkg::WORD_SIZE-1:0]       i_addr,
    input  logic [cache_pkg::WORD_SIZE-1:0]       i_wdata,
    input  logic                                  i_mem_ack,
    input  logic [cache_pkg::BLOCK_SIZE-1:0]      i_mem_rdata,
    output logic                                  o_ack,
    output logic [cache_pkg::WORD_SIZE-1:0]       o_rdata,
    output logic                                  o_mem_req,
    output logic                                  o_mem_we,
    output logic [cache_pkg::BLOCK_ADDR_SIZE-1:0] o_mem_addr,
    output logic [cache_pkg::BLOCK_SIZE-1:0]      o_mem_wdata,
    output logic [15:0]                           o_miss_count
);
    import cache_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_WRITEBACK,
        S_WB_CLOSE,
        S_REFILL,
        S_LOOKUP,
        S_RESPOND
    } state_t;

    state_t                 state;
    logic [TAG_SIZE-1:0]    tag_mem  [NUM_LINES];
    logic [BLOCK_SIZE-1:0]  data_mem [NUM_LINES];
    logic [NUM_LINES-1:0]   valid;
    logic [NUM_LINES-1:0]   dirty;

    logic [TAG_SIZE-1:0]    addr_tag;
    logic [INDEX_SIZE-1:0]  addr_index;
    logic [OFFSET_SIZE-1:0] word_sel;
    logic                   hit;
    logic                   victim_dirty;
    logic                   start;
    logic                   answer;
    logic                   start_wb;
    logic                   start_fill;
    logic                   fill_done;

    assign addr_tag     = i_addr[WORD_SIZE-1 -: TAG_SIZE];
    assign addr_index   = i_addr[OFFSET_SIZE +: INDEX_SIZE];
    assign word_sel     = OFFSET_SIZE'(LINE_WORDS - 1) - i_addr[OFFSET_SIZE-1:0];
    assign hit          = valid[addr_index] && (tag_mem[addr_index] == addr_tag);
    assign victim_dirty = valid[addr_index] && dirty[addr_index];

    assign start    = (state == S_IDLE) && i_req;
    // after a refill the line is a hit, so the write merge reuses the hit path
    assign answer   = (start && hit) || ((state == S_LOOKUP) && !i_mem_ack);
    assign start_wb = start && !hit && victim_dirty;
    assign start_fill = (start && !hit && !victim_dirty)
                      || ((state == S_WB_CLOSE) && !i_mem_ack);
    assign fill_done = (state == S_REFILL) && i_mem_ack;

    always_ff @(posedge Clk) begin
        if (i_reset) begin
            state        <= S_IDLE;
            o_ack        <= 1'b0;
            o_mem_req    <= 1'b0;
            valid        <= '0;
            dirty        <= '0;
            o_miss_count <= '0;
        end else begin
            unique case (state)
                S_IDLE: begin
                    if (answer) begin
                        o_ack <= 1'b1;
                        state <= S_RESPOND;
                    end else if (start) begin
                        o_mem_req    <= 1'b1;
                        o_miss_count <= o_miss_count + 16'd1;
                        state        <= start_wb ? S_WRITEBACK : S_REFILL;
                    end
                end
                S_WRITEBACK: begin
                    if (i_mem_ack) begin
                        o_mem_req <= 1'b0;
                        state     <= S_WB_CLOSE;
                    end
                end
                // the read may only start after the write handshake is closed
                S_WB_CLOSE: begin
                    if (start_fill) begin
                        o_mem_req <= 1'b1;
                        state     <= S_REFILL;
                    end
                end
                S_REFILL: begin
                    if (fill_done) begin
                        o_mem_req         <= 1'b0;
                        valid[addr_index] <= 1'b1;
                        dirty[addr_index] <= 1'b0;
                        state             <= S_LOOKUP;
                    end
                end
                S_LOOKUP: begin
                    if (answer) begin
                        o_ack <= 1'b1;
                        state <= S_RESPOND;
                    end
                end
                S_RESPOND: begin
                    if (!i_req) begin
                        o_ack <= 1'b0;
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
            if (answer && i_we) begin
                dirty[addr_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (start_wb) begin
            o_mem_we    <= 1'b1;
            o_mem_addr  <= {tag_mem[addr_index], addr_index};
            o_mem_wdata <= data_mem[addr_index];
        end
        if (start_fill) begin
            o_mem_we   <= 1'b0;
            o_mem_addr <= i_addr[WORD_SIZE-1:OFFSET_SIZE];
        end
        if (fill_done) begin
            tag_mem[addr_index]  <= addr_tag;
            data_mem[addr_index] <= i_mem_rdata;
        end
        if (answer) begin
            if (i_we) begin
                data_mem[addr_index][word_sel*WORD_SIZE +: WORD_SIZE] <= i_wdata;
                o_rdata <= i_wdata;
            end else begin
                o_rdata <= data_mem[addr_index][word_sel*WORD_SIZE +: WORD_SIZE];
            end
        end
    end

endmodule

// File: rtl/icache.sv
`timescale 1ns/1ps

module icache (
    input  logic                                  Clk,
    input  logic                                  i_reset,
    input  logic                                  i_req,
    input  logic [cache_pkg::WORD_SIZE-1:0]       i_addr,
    input  logic                                  i_mem_ack,
    input  logic [cache_pkg::BLOCK_SIZE-1:0]      i_mem_rdata,
    output logic                                  o_ack,
    output logic [cache_pkg::WORD_SIZE-1:0]       o_rdata,
    output logic                                  o_mem_req,
    output logic [cache_pkg::BLOCK_ADDR_SIZE-1:0] o_mem_addr,
    output logic [15:0]                           o_miss_count
);
    import cache_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_REFILL, S_LOOKUP, S_RESPOND} state_t;

    state_t                 state;
    logic [TAG_SIZE-1:0]    tag_mem  [NUM_LINES];
    logic [BLOCK_SIZE-1:0]  data_mem [NUM_LINES];
    logic [NUM_LINES-1:0]   valid;

    logic [TAG_SIZE-1:0]    addr_tag;
    logic [INDEX_SIZE-1:0]  addr_index;
    logic [OFFSET_SIZE-1:0] word_sel;
    logic                   hit;
    logic                   start;
    logic                   answer;
    logic                   fill_done;

    assign addr_tag   = i_addr[WORD_SIZE-1 -: TAG_SIZE];
    assign addr_index = i_addr[OFFSET_SIZE +: INDEX_SIZE];
    // word 0 lives in the top bits, so the slice position counts down
    assign word_sel   = OFFSET_SIZE'(LINE_WORDS - 1) - i_addr[OFFSET_SIZE-1:0];
    assign hit        = valid[addr_index] && (tag_mem[addr_index] == addr_tag);

    assign start     = (state == S_IDLE) && i_req;
    assign answer    = (start && hit) || ((state == S_LOOKUP) && !i_mem_ack);
    assign fill_done = (state == S_REFILL) && i_mem_ack;

    always_ff @(posedge Clk) begin
        if (i_reset) begin
            state        <= S_IDLE;
            o_ack        <= 1'b0;
            o_mem_req    <= 1'b0;
            valid        <= '0;
            o_miss_count <= '0;
        end else begin
            unique case (state)
                S_IDLE: begin
                    if (answer) begin
                        o_ack <= 1'b1;
                        state <= S_RESPOND;
                    end else if (start) begin
                        o_mem_req    <= 1'b1;
                        o_miss_count <= o_miss_count + 16'd1;
                        state        <= S_REFILL;
                    end
                end
                S_REFILL: begin
                    if (fill_done) begin
                        o_mem_req         <= 1'b0;
                        valid[addr_index] <= 1'b1;
                        state             <= S_LOOKUP;
                    end
                end
                // the new line answers once the memory has dropped its ack
                S_LOOKUP: begin
                    if (answer) begin
                        o_ack <= 1'b1;
                        state <= S_RESPOND;
                    end
                end
                S_RESPOND: begin
                    if (!i_req) begin
                        o_ack <= 1'b0;
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (start && !hit) begin
            o_mem_addr <= i_addr[WORD_SIZE-1:OFFSET_SIZE];
        end
        if (fill_done) begin
            tag_mem[addr_index]  <= addr_tag;
            data_mem[addr_index] <= i_mem_rdata;
        end
        if (answer) begin
            o_rdata <= data_mem[addr_index][word_sel*WORD_SIZE +: WORD_SIZE];
        end
    end

endmodule

// File: rtl/cache_pkg.sv
package cache_pkg;

    // CPU word and line geometry
    localparam int WORD_SIZE  = 16;
    localparam int LINE_WORDS = 4;
    localparam int NUM_LINES  = 8;

    // address split, from the top bit down: tag, index, word offset
    localparam int INDEX_SIZE  = 3;
    localparam int OFFSET_SIZE = 2;
    localparam int TAG_SIZE    = WORD_SIZE - INDEX_SIZE - OFFSET_SIZE;

    // one memory block holds a whole line, word 0 in the top bits
    localparam int BLOCK_SIZE = WORD_SIZE * LINE_WORDS;

    // block address is the word address without its offset bits
    localparam int BLOCK_ADDR_SIZE = TAG_SIZE + INDEX_SIZE;

    // every word of the backing memory starts as its own address xor this value
    localparam logic [WORD_SIZE-1:0] MEM_PATTERN = 16'h5a5a;

endpackage
